// File: design/blur_pkg.sv
`default_nettype none

package blur_pkg;

    // Pixel sample width
    localparam int PIXEL_W = 12;

    // Filter mode, sampled with the start-of-packet beat
    typedef enum logic [1:0] {
        MODE_BYPASS = 2'd0,
        MODE_BLUR3  = 2'd1,
        MODE_BLUR5  = 2'd2
    } kernel_mode_e;

    // 5x5 weight table, 1 2 3 2 1 / 2 3 4 3 2 / 3 4 4 4 3 / 2 3 4 3 2 / 1 2 3 2 1
    // Weight falls by one per step of Manhattan distance, capped at 4 in the middle
    function automatic logic [2:0] kernel_weight(input int row, input int col);
        int dr;
        int dc;
        int w;
        dr = (row > 2) ? row - 2 : 2 - row;
        dc = (col > 2) ? col - 2 : 2 - col;
        w = 5 - dr - dc;
        if (w > 4) begin
            w = 4;
        end
        return 3'(w);
    endfunction

    // Window radius per mode
    function automatic logic [1:0] mode_radius(input kernel_mode_e m);
        case (m)
            MODE_BLUR3: return 2'd1;
            MODE_BLUR5: return 2'd2;
            default:    return 2'd0;
        endcase
    endfunction

    // Normalising shift, log2 of the weight total
    function automatic logic [2:0] mode_shift(input kernel_mode_e m);
        case (m)
            MODE_BLUR3: return 3'd5;
            MODE_BLUR5: return 3'd6;
            default:    return 3'd0;
        endcase
    endfunction

endpackage

`default_nettype wire

// File: design/line_buffer.sv
`timescale 1ns/1ps
`default_nettype none

module line_buffer #(
    parameter int IMG_WIDTH = 16,
    localparam int PTR_W = (IMG_WIDTH > 1) ? $clog2(IMG_WIDTH) : 1
) (
    input  wire logic                                 clk,
    input  wire logic                                 rst_n,
    input  wire logic                                 advance,
    input  wire logic [blur_pkg::PIXEL_W-1:0]         pixel,
    output logic      [4:0][blur_pkg::PIXEL_W-1:0]    column_data
);

    localparam logic [PTR_W-1:0] PTR_LAST = PTR_W'(IMG_WIDTH - 1);

    // Line 0 holds the row written one line ago, line 3 four lines ago
    logic [blur_pkg::PIXEL_W-1:0] line0 [IMG_WIDTH];
    logic [blur_pkg::PIXEL_W-1:0] line1 [IMG_WIDTH];
    logic [blur_pkg::PIXEL_W-1:0] line2 [IMG_WIDTH];
    logic [blur_pkg::PIXEL_W-1:0] line3 [IMG_WIDTH];

    // Column pointer, one step per accepted beat
    logic [PTR_W-1:0] col_ptr;

    // Stored column at the pointer plus the new pixel
    // Oldest row first, new pixel last
    assign column_data[0] = line3[col_ptr];
    assign column_data[1] = line2[col_ptr];
    assign column_data[2] = line1[col_ptr];
    assign column_data[3] = line0[col_ptr];
    assign column_data[4] = pixel;

    // The pointer runs free across frames
    // Each slot always holds the beat written IMG_WIDTH beats earlier,
    // so frame length need not be a multiple of the width
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            col_ptr <= '0;
        end else if (advance) begin
            if (col_ptr == PTR_LAST) begin
                col_ptr <= '0;
            end else begin
                col_ptr <= col_ptr + PTR_W'(1);
            end
        end
    end

    // Push the column down by one line
    // Oldest sample drops out of line 3
    always_ff @(posedge clk) begin
        if (advance) begin
            line0[col_ptr] <= pixel;
            line1[col_ptr] <= line0[col_ptr];
            line2[col_ptr] <= line1[col_ptr];
            line3[col_ptr] <= line2[col_ptr];
        end
    end

endmodule

`default_nettype wire

// File: design/window_shift.sv
`timescale 1ns/1ps
`default_nettype none

module window_shift #(
    parameter int IMG_WIDTH  = 16,
    parameter int IMG_HEIGHT = 8,
    localparam int ROW_W = $clog2(IMG_HEIGHT) + 2,
    localparam int COL_W = $clog2(IMG_WIDTH) + 2
) (
    input  wire logic                                      clk,
    input  wire logic                                      rst_n,
    input  wire logic                                      advance,
    input  wire logic                                      src_ready,
    input  wire logic [4:0][blur_pkg::PIXEL_W-1:0]         column_data,
    input  wire logic signed [ROW_W-1:0]                   ctr_row,
    input  wire logic signed [COL_W-1:0]                   ctr_col,
    input  wire logic                                      ctr_valid,
    input  wire logic                                      out_sop,
    input  wire logic                                      out_eop,
    input  wire blur_pkg::kernel_mode_e                    frame_mode,
    output logic      [4:0][4:0][blur_pkg::PIXEL_W-1:0]    win_pixels,
    output logic                                           win_valid,
    output logic                                           win_sop,
    output logic                                           win_eop,
    output blur_pkg::kernel_mode_e                         win_mode
);

    // Raw window, [row][col], row 0 oldest line, col 4 newest column
    logic [4:0][4:0][blur_pkg::PIXEL_W-1:0] win_raw;
    logic [4:0][4:0][blur_pkg::PIXEL_W-1:0] masked;
    logic [1:0]                              rad;

    assign rad = blur_pkg::mode_radius(frame_mode);

    // Shift one column in per accepted beat
    always_ff @(posedge clk) begin
        if (advance) begin
            for (int i = 0; i < 5; i++) begin
                for (int j = 0; j < 4; j++) begin
                    win_raw[i][j] <= win_raw[i][j+1];
                end
                win_raw[i][4] <= column_data[i];
            end
        end
    end

    // The centre sits R samples behind the newest one
    // Re-centre so the kernel always sees the centre at [2][2]
    // Taps beyond the newest sample and taps off the frame read as zero
    always_comb begin
        int src_i;
        int src_j;
        int img_r;
        int img_c;
        for (int i = 0; i < 5; i++) begin
            for (int j = 0; j < 5; j++) begin
                src_i = i + 2 - int'(rad);
                src_j = j + 2 - int'(rad);
                img_r = int'(ctr_row) + i - 2;
                img_c = int'(ctr_col) + j - 2;
                masked[i][j] = '0;
                if (src_i <= 4 && src_j <= 4 &&
                    img_r >= 0 && img_r < IMG_HEIGHT &&
                    img_c >= 0 && img_c < IMG_WIDTH) begin
                    masked[i][j] = win_raw[src_i][src_j];
                end
            end
        end
    end

    // Masked copy, moves with the global stall
    always_ff @(posedge clk) begin
        if (src_ready) begin
            win_pixels <= masked;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            win_valid <= 1'b0;
            win_sop   <= 1'b0;
            win_eop   <= 1'b0;
            win_mode  <= blur_pkg::MODE_BYPASS;
        end else if (src_ready) begin
            win_valid <= ctr_valid;
            win_sop   <= out_sop;
            win_eop   <= out_eop;
            win_mode  <= frame_mode;
        end
    end

endmodule

`default_nettype wire

// File: design/blur_kernel.sv
`timescale 1ns/1ps
`default_nettype none

module blur_kernel (
    input  wire logic                                      clk,
    input  wire logic                                      rst_n,
    input  wire logic                                      src_ready,
    input  wire logic [4:0][4:0][blur_pkg::PIXEL_W-1:0]    win_pixels,
    input  wire logic                                      win_valid,
    input  wire logic                                      win_sop,
    input  wire logic                                      win_eop,
    input  wire blur_pkg::kernel_mode_e                    win_mode,
    output logic                                           src_valid,
    output logic                                           src_sop,
    output logic                                           src_eop,
    output logic      [blur_pkg::PIXEL_W-1:0]              src_data
);

    // Weight total 64 adds six bits of headroom
    localparam int SUM_W = blur_pkg::PIXEL_W + 6;

    logic [4:0][SUM_W-1:0]           row_sum_c;
    logic [SUM_W-1:0]                total_c;
    logic [SUM_W-1:0]                shifted_c;

    // Stage 1 registers
    logic [4:0][SUM_W-1:0]           s1_row;
    logic [blur_pkg::PIXEL_W-1:0]    s1_centre;
    blur_pkg::kernel_mode_e          s1_mode;
    logic                            s1_valid;
    logic                            s1_sop;
    logic                            s1_eop;

    // Stage 2 registers
    logic [SUM_W-1:0]                s2_total;
    logic [blur_pkg::PIXEL_W-1:0]    s2_centre;
    blur_pkg::kernel_mode_e          s2_mode;
    logic                            s2_valid;
    logic                            s2_sop;
    logic                            s2_eop;

    // Weighted row sums
    // 3x3 mode keeps only the inner taps, whose weights total 32
    always_comb begin
        logic use_tap;
        for (int i = 0; i < 5; i++) begin
            row_sum_c[i] = '0;
            for (int j = 0; j < 5; j++) begin
                use_tap = (win_mode == blur_pkg::MODE_BLUR5) ||
                          (win_mode == blur_pkg::MODE_BLUR3 &&
                           i >= 1 && i <= 3 && j >= 1 && j <= 3);
                if (use_tap) begin
                    row_sum_c[i] = row_sum_c[i] +
                        SUM_W'(blur_pkg::kernel_weight(i, j)) * SUM_W'(win_pixels[i][j]);
                end
            end
        end
    end

    assign total_c = s1_row[0] + s1_row[1] + s1_row[2] + s1_row[3] + s1_row[4];

    // Divide by the weight total
    assign shifted_c = s2_total >> blur_pkg::mode_shift(s2_mode);

    // Datapath, all stages hold while the sink stalls
    always_ff @(posedge clk) begin
        if (src_ready) begin
            s1_row    <= row_sum_c;
            s1_centre <= win_pixels[2][2];
            s2_total  <= total_c;
            s2_centre <= s1_centre;
            // Bypass returns the centre tap untouched
            if (s2_mode == blur_pkg::MODE_BYPASS) begin
                src_data <= s2_centre;
            end else begin
                src_data <= shifted_c[blur_pkg::PIXEL_W-1:0];
            end
        end
    end

    // Valid, packet tags and mode travel with the sum
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            s1_valid  <= 1'b0;
            s1_sop    <= 1'b0;
            s1_eop    <= 1'b0;
            s1_mode   <= blur_pkg::MODE_BYPASS;
            s2_valid  <= 1'b0;
            s2_sop    <= 1'b0;
            s2_eop    <= 1'b0;
            s2_mode   <= blur_pkg::MODE_BYPASS;
            src_valid <= 1'b0;
            src_sop   <= 1'b0;
            src_eop   <= 1'b0;
        end else if (src_ready) begin
            s1_valid  <= win_valid;
            s1_sop    <= win_sop;
            s1_eop    <= win_eop;
            s1_mode   <= win_mode;
            s2_valid  <= s1_valid;
            s2_sop    <= s1_sop;
            s2_eop    <= s1_eop;
            s2_mode   <= s1_mode;
            src_valid <= s2_valid;
            src_sop   <= s2_sop;
            src_eop   <= s2_eop;
        end
    end

endmodule

`default_nettype wire

// File: design/frame_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module frame_ctrl #(
    parameter int IMG_WIDTH  = 16,
    parameter int IMG_HEIGHT = 8,
    localparam int ROW_W = $clog2(IMG_HEIGHT) + 2,
    localparam int COL_W = $clog2(IMG_WIDTH) + 2
) (
    input  wire logic                      clk,
    input  wire logic                      rst_n,
    input  wire logic                      snk_valid,
    input  wire logic                      snk_sop,
    input  wire logic                      snk_eop,
    input  wire logic                      src_ready,
    input  wire blur_pkg::kernel_mode_e    mode,
    output logic                           snk_ready,
    output logic                           advance,
    output logic [ROW_W-1:0]               wr_row,
    output logic [COL_W-1:0]               wr_col,
    output logic signed [ROW_W-1:0]        ctr_row,
    output logic signed [COL_W-1:0]        ctr_col,
    output logic                           ctr_valid,
    output logic                           out_sop,
    output logic                           out_eop,
    output blur_pkg::kernel_mode_e         frame_mode
);

    localparam logic [ROW_W-1:0] H_U = ROW_W'(IMG_HEIGHT);
    localparam logic [COL_W-1:0] W_U = COL_W'(IMG_WIDTH);

    typedef enum logic [1:0] {ST_IDLE, ST_STREAM, ST_FLUSH} state_e;

    state_e                   state;
    blur_pkg::kernel_mode_e   cur_mode;
    logic [1:0]               rad;
    logic [ROW_W-1:0]         rad_r;
    logic [ROW_W-1:0]         row_u;
    logic [COL_W-1:0]         rad_c;
    logic [COL_W-1:0]         col_u;
    logic                     flushing;
    logic                     snk_beat;
    logic                     col_wrap;
    logic                     in_frame;
    logic                     last_flush;
    logic                     frame_done;

    // Upstream is held off for the whole flush
    assign flushing  = state == ST_FLUSH;
    assign snk_ready = src_ready && !flushing;
    assign snk_beat  = snk_valid && snk_ready;
    assign advance   = snk_beat || (src_ready && flushing);

    // Sop beat already uses the mode it carries
    assign cur_mode = (snk_beat && snk_sop) ? mode : frame_mode;
    assign rad      = blur_pkg::mode_radius(cur_mode);
    assign rad_r    = ROW_W'(rad);
    assign rad_c    = COL_W'(rad);

    // Centre is R rows and R columns behind the write position
    // Negative rows wrap to large values and fail the range check
    assign col_wrap = wr_col < rad_c;
    assign col_u    = wr_col - rad_c + (col_wrap ? W_U : '0);
    assign row_u    = wr_row - rad_r - ROW_W'(col_wrap);
    assign in_frame = row_u < H_U && col_u < W_U;

    // Flush ends once position (H+R, R-1) is written
    assign last_flush = flushing && wr_row == H_U + rad_r && wr_col == rad_c - COL_W'(1);
    // Bypass needs no flush
    assign frame_done = last_flush || (snk_beat && snk_eop && rad == 2'd0);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state      <= ST_IDLE;
            wr_row     <= '0;
            wr_col     <= '0;
            frame_mode <= blur_pkg::MODE_BYPASS;
        end else if (advance) begin
            if (snk_beat && snk_sop) begin
                frame_mode <= mode;
            end
            if (frame_done) begin
                state  <= ST_IDLE;
                wr_row <= '0;
                wr_col <= '0;
            end else begin
                if (snk_beat && snk_eop) begin
                    state <= ST_FLUSH;
                end else if (state == ST_IDLE) begin
                    state <= ST_STREAM;
                end
                // Raster order, flush beats run on past the last row
                if (wr_col == W_U - COL_W'(1)) begin
                    wr_col <= '0;
                    wr_row <= wr_row + ROW_W'(1);
                end else begin
                    wr_col <= wr_col + COL_W'(1);
                end
            end
        end
    end

    // Centre flags line up with the window loaded on the same edge
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            ctr_valid <= 1'b0;
            out_sop   <= 1'b0;
            out_eop   <= 1'b0;
        end else if (src_ready) begin
            ctr_valid <= advance && in_frame;
            out_sop   <= advance && in_frame && row_u == '0 && col_u == '0;
            out_eop   <= advance && in_frame &&
                         row_u == H_U - ROW_W'(1) && col_u == W_U - COL_W'(1);
        end
    end

    always_ff @(posedge clk) begin
        if (advance) begin
            ctr_row <= $signed(row_u);
            ctr_col <= $signed(col_u);
        end
    end

endmodule

`default_nettype wire

// File: design/video_blur_top.sv
`timescale 1ns/1ps
`default_nettype none

module video_blur_top #(
    parameter int IMG_WIDTH  = 16,
    parameter int IMG_HEIGHT = 8,
    localparam int ROW_W = $clog2(IMG_HEIGHT) + 2,
    localparam int COL_W = $clog2(IMG_WIDTH) + 2
) (
    input  wire logic                              clk,
    input  wire logic                              rst_n,
    input  wire blur_pkg::kernel_mode_e            mode,
    input  wire logic                              snk_valid,
    input  wire logic                              snk_sop,
    input  wire logic                              snk_eop,
    input  wire logic [blur_pkg::PIXEL_W-1:0]      snk_data,
    output logic                                   snk_ready,
    output logic                                   src_valid,
    output logic                                   src_sop,
    output logic                                   src_eop,
    output logic      [blur_pkg::PIXEL_W-1:0]      src_data,
    input  wire logic                              src_ready
);

    logic                                    advance;
    logic signed [ROW_W-1:0]                 ctr_row;
    logic signed [COL_W-1:0]                 ctr_col;
    logic                                    ctr_valid;
    logic                                    out_sop;
    logic                                    out_eop;
    blur_pkg::kernel_mode_e                  frame_mode;
    logic [blur_pkg::PIXEL_W-1:0]            pixel;
    logic [4:0][blur_pkg::PIXEL_W-1:0]       column_data;
    logic [4:0][4:0][blur_pkg::PIXEL_W-1:0]  win_pixels;
    logic                                    win_valid;
    logic                                    win_sop;
    logic                                    win_eop;
    blur_pkg::kernel_mode_e                  win_mode;

    // Flush beats write zeros, snk_ready is low only then or while stalled
    assign pixel = snk_ready ? snk_data : '0;

    frame_ctrl #(.IMG_WIDTH(IMG_WIDTH), .IMG_HEIGHT(IMG_HEIGHT)) i_frame_ctrl (
        .clk(clk), .rst_n(rst_n), .snk_valid(snk_valid), .snk_sop(snk_sop),
        .snk_eop(snk_eop), .src_ready(src_ready), .mode(mode), .snk_ready(snk_ready),
        .advance(advance), .wr_row(), .wr_col(), .ctr_row(ctr_row), .ctr_col(ctr_col),
        .ctr_valid(ctr_valid), .out_sop(out_sop), .out_eop(out_eop),
        .frame_mode(frame_mode)
    );

    line_buffer #(.IMG_WIDTH(IMG_WIDTH)) i_line_buffer (
        .clk(clk), .rst_n(rst_n), .advance(advance), .pixel(pixel),
        .column_data(column_data)
    );

    window_shift #(.IMG_WIDTH(IMG_WIDTH), .IMG_HEIGHT(IMG_HEIGHT)) i_window_shift (
        .clk(clk), .rst_n(rst_n), .advance(advance), .src_ready(src_ready),
        .column_data(column_data),
        .ctr_row(ctr_row), .ctr_col(ctr_col), .ctr_valid(ctr_valid),
        .out_sop(out_sop), .out_eop(out_eop), .frame_mode(frame_mode),
        .win_pixels(win_pixels), .win_valid(win_valid), .win_sop(win_sop),
        .win_eop(win_eop), .win_mode(win_mode)
    );

    blur_kernel i_blur_kernel (
        .clk(clk), .rst_n(rst_n), .src_ready(src_ready), .win_pixels(win_pixels),
        .win_valid(win_valid), .win_sop(win_sop), .win_eop(win_eop),
        .win_mode(win_mode), .src_valid(src_valid), .src_sop(src_sop),
        .src_eop(src_eop), .src_data(src_data)
    );

endmodule

`default_nettype wire

// File: test/tb_video_blur.sv
`timescale 1ns/1ps
`default_nettype none

module tb_video_blur;

    localparam int IMG_WIDTH    = 16;
    localparam int IMG_HEIGHT   = 8;
    localparam int NPIX         = IMG_WIDTH * IMG_HEIGHT;
    localparam int PIX_W        = blur_pkg::PIXEL_W;
    localparam int NUM_FRAMES   = 12;
    localparam int CLK_PERIOD   = 20;
    localparam int RESET_CYCLES = 16;
    localparam int DRAIN_CYCLES = 200;
    // Four cycles per pixel covers gaps, stalls and the flush, plus a fixed margin
    localparam int TIMEOUT_CYCLES = NUM_FRAMES * NPIX * 4 + 2000;

    logic                    clk;
    logic                    rst_n;
    blur_pkg::kernel_mode_e  mode;
    logic                    snk_valid;
    logic                    snk_sop;
    logic                    snk_eop;
    logic [PIX_W-1:0]        snk_data;
    logic                    snk_ready;
    logic                    src_valid;
    logic                    src_sop;
    logic                    src_eop;
    logic [PIX_W-1:0]        src_data;
    logic                    src_ready;

    // Stored stimulus, one entry per frame
    logic [PIX_W-1:0]        sent_pix [NUM_FRAMES][NPIX];
    blur_pkg::kernel_mode_e  sent_mode [NUM_FRAMES];

    // Monitor position and stall tracking
    int                      out_frame;
    int                      out_beat;
    logic                    held;
    logic [PIX_W-1:0]        held_data;
    int                      stall_left;

    int                      pixel_errors;
    int                      flag_errors;
    int                      length_errors;
    int                      other_errors;

    video_blur_top #(.IMG_WIDTH(IMG_WIDTH), .IMG_HEIGHT(IMG_HEIGHT)) i_video_blur_top (
        .clk(clk), .rst_n(rst_n), .mode(mode), .snk_valid(snk_valid),
        .snk_sop(snk_sop), .snk_eop(snk_eop), .snk_data(snk_data),
        .snk_ready(snk_ready), .src_valid(src_valid), .src_sop(src_sop),
        .src_eop(src_eop), .src_data(src_data), .src_ready(src_ready)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    function automatic blur_pkg::kernel_mode_e random_mode();
        int pick;
        pick = $urandom_range(2, 0);
        case (pick)
            1:       return blur_pkg::MODE_BLUR3;
            2:       return blur_pkg::MODE_BLUR5;
            default: return blur_pkg::MODE_BYPASS;
        endcase
    endfunction

    // Reference model with zero padding, the sum still divided by the full total
    function automatic logic [PIX_W-1:0] expected_pixel(input int f, input int r, input int c);
        int rad;
        int sum;
        int rr;
        int cc;
        rad = int'(blur_pkg::mode_radius(sent_mode[f]));
        if (rad == 0) begin
            return sent_pix[f][r * IMG_WIDTH + c];
        end
        sum = 0;
        for (int dr = -rad; dr <= rad; dr++) begin
            for (int dc = -rad; dc <= rad; dc++) begin
                rr = r + dr;
                cc = c + dc;
                if (rr >= 0 && rr < IMG_HEIGHT && cc >= 0 && cc < IMG_WIDTH) begin
                    sum += int'(blur_pkg::kernel_weight(2 + dr, 2 + dc)) *
                           int'(sent_pix[f][rr * IMG_WIDTH + cc]);
                end
            end
        end
        return PIX_W'(sum >> blur_pkg::mode_shift(sent_mode[f]));
    endfunction

    task automatic check_pixel(input string name, input logic [PIX_W-1:0] got,
                               input logic [PIX_W-1:0] exp);
        if (got !== exp) begin
            pixel_errors++;
            $display("[ERROR] %s frame %0d beat %0d: got 0x%03h expected 0x%03h",
                     name, out_frame, out_beat, got, exp);
        end
    endtask

    task automatic check_flag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            flag_errors++;
            $display("[ERROR] %s frame %0d beat %0d: got 0x%0h expected 0x%0h",
                     name, out_frame, out_beat, got, exp);
        end
    endtask

    task automatic check_mode_frame(input int f, input blur_pkg::kernel_mode_e m,
                                    input int got_len);
        if (got_len != NPIX) begin
            length_errors++;
            $display("Frame %0d in mode %s ended after %0d beats instead of %0d",
                     f, m.name(), got_len, NPIX);
        end
    endtask

    // Random pixels, all three modes within the first three frames
    task automatic build_frames();
        int first;
        first = $urandom_range(2, 0);
        for (int f = 0; f < NUM_FRAMES; f++) begin
            if (f < 3) begin
                case ((first + f) % 3)
                    1:       sent_mode[f] = blur_pkg::MODE_BLUR3;
                    2:       sent_mode[f] = blur_pkg::MODE_BLUR5;
                    default: sent_mode[f] = blur_pkg::MODE_BYPASS;
                endcase
            end else begin
                sent_mode[f] = random_mode();
            end
            for (int i = 0; i < NPIX; i++) begin
                sent_pix[f][i] = PIX_W'($urandom);
            end
        end
    endtask

    // One frame in raster order with random gaps in snk_valid
    // Mode is random on every beat but the sop beat
    task automatic send_frame(input int f);
        int idx;
        idx = 0;
        while (idx < NPIX) begin
            @(negedge clk);
            if ($urandom_range(3, 0) == 0) begin
                snk_valid = 1'b0;
                snk_sop   = 1'b0;
                snk_eop   = 1'b0;
                snk_data  = PIX_W'($urandom);
                mode      = random_mode();
            end else begin
                snk_valid = 1'b1;
                snk_sop   = (idx == 0);
                snk_eop   = (idx == NPIX - 1);
                snk_data  = sent_pix[f][idx];
                mode      = (idx == 0) ? sent_mode[f] : random_mode();
            end
            @(posedge clk);
            if (snk_valid && snk_ready) begin
                idx++;
            end
        end
    endtask

    // Back-pressure in random bursts
    initial begin
        stall_left = 0;
        wait (rst_n === 1'b1);
        forever begin
            @(negedge clk);
            if (stall_left > 0) begin
                src_ready  = 1'b0;
                stall_left--;
            end else if ($urandom_range(7, 0) == 0) begin
                src_ready  = 1'b0;
                stall_left = $urandom_range(5, 0);
            end else begin
                src_ready  = 1'b1;
            end
        end
    end

    // Output monitor
    always @(posedge clk) begin
        if (rst_n) begin
            // Upstream is held off whenever the sink stalls
            if (!src_ready) begin
                check_flag("snk_ready", snk_ready, 1'b0);
            end
            // A stalled beat must stay valid with the same data
            if (held) begin
                check_flag("src_valid", src_valid, 1'b1);
                check_pixel("src_data", src_data, held_data);
            end
            held      = src_valid && !src_ready;
            held_data = src_data;
            if (src_valid && src_ready) begin
                if (out_frame >= NUM_FRAMES) begin
                    other_errors++;
                    $display("Output beat with data 0x%03h after the last frame", src_data);
                end else begin
                    check_flag("src_sop", src_sop, out_beat == 0);
                    check_flag("src_eop", src_eop, out_beat == NPIX - 1);
                    check_pixel("src_data", src_data,
                                expected_pixel(out_frame, out_beat / IMG_WIDTH,
                                               out_beat % IMG_WIDTH));
                    // Close on eop, or at full length when eop is missing
                    if (src_eop || out_beat == NPIX - 1) begin
                        check_mode_frame(out_frame, sent_mode[out_frame], out_beat + 1);
                        out_frame++;
                        out_beat = 0;
                    end else begin
                        out_beat++;
                    end
                end
            end
        end
    end

    // Watchdog
    initial begin
        repeat (TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout with %0d of %0d frames received", out_frame, NUM_FRAMES);
        $display("sim failed");
        $finish;
    end

    initial begin
        rst_n         = 1'b0;
        mode          = blur_pkg::MODE_BYPASS;
        snk_valid     = 1'b0;
        snk_sop       = 1'b0;
        snk_eop       = 1'b0;
        snk_data      = '0;
        src_ready     = 1'b1;
        out_frame     = 0;
        out_beat      = 0;
        held          = 1'b0;
        held_data     = '0;
        pixel_errors  = 0;
        flag_errors   = 0;
        length_errors = 0;
        other_errors  = 0;
        void'($urandom(32'ha85d));
        build_frames();

        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        // Idle stream after reset
        check_flag("src_valid", src_valid, 1'b0);
        check_flag("src_sop", src_sop, 1'b0);
        check_flag("src_eop", src_eop, 1'b0);
        check_flag("snk_ready", snk_ready, src_ready);
        rst_n = 1'b1;

        for (int f = 0; f < NUM_FRAMES; f++) begin
            send_frame(f);
        end
        @(negedge clk);
        snk_valid = 1'b0;
        snk_sop   = 1'b0;
        snk_eop   = 1'b0;

        wait (out_frame == NUM_FRAMES);
        // Extra cycles catch duplicated beats
        repeat (DRAIN_CYCLES) @(posedge clk);

        $display("Errors: pixel %0d, flag %0d, length %0d, other %0d",
                 pixel_errors, flag_errors, length_errors, other_errors);
        if (pixel_errors + flag_errors + length_errors + other_errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: build.f
design/blur_pkg.sv
design/line_buffer.sv
design/window_shift.sv
design/blur_kernel.sv
design/frame_ctrl.sv
design/video_blur_top.sv
test/tb_video_blur.sv

// File: Makefile
VERILATOR := verilator
TOP       := tb_video_blur
FILELIST  := build.f
OBJ_DIR   := obj_dir
VFLAGS    := --binary --timing -j 0 --top-module $(TOP) --Mdir $(OBJ_DIR)
LOG       := sim.log
FAIL_MSG  := sim failed

SOURCES := $(shell grep -E '\.s?v$$' $(FILELIST))
SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(SIM_BIN)

# Rebuilt only when a source or the file list changes
$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ]; then exit 1; fi
	@if grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation reported failure"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
